/* design/axi_pte_reader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ptw_consts.svh"

module axi_pte_reader (
    input  logic                 clk,
    input  logic                 rst,
    pte_rd_if.reader             rd,
    output logic [`PTW_XLEN-1:0] m_axi_araddr,
    output logic                 m_axi_arvalid,
    input  logic                 m_axi_arready,
    output logic [7:0]           m_axi_arlen,
    output logic [2:0]           m_axi_arsize,
    output logic [1:0]           m_axi_arburst,
    output logic [`PTW_ID_W-1:0] m_axi_arid,
    input  logic [`PTW_XLEN-1:0] m_axi_rdata,
    input  logic                 m_axi_rlast,
    input  logic                 m_axi_rvalid,
    output logic                 m_axi_rready
);

    localparam logic [1:0] rd_idle = 2'd0;
    localparam logic [1:0] rd_addr = 2'd1;  // arvalid held
    localparam logic [1:0] rd_data = 2'd2;  // rready held
    localparam logic [1:0] rd_done = 2'd3;  // data back to the walker

    logic [1:0]           state_q;
    logic [`PTW_XLEN-1:0] data_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q       <= rd_idle;
            m_axi_arvalid <= 1'b0;
            m_axi_rready  <= 1'b0;
        end else begin
            case (state_q)
                rd_idle:
                    if (rd.req) begin
                        m_axi_arvalid <= 1'b1;
                        state_q       <= rd_addr;
                    end
                rd_addr:
                    if (m_axi_arready) begin
                        m_axi_arvalid <= 1'b0;
                        m_axi_rready  <= 1'b1;
                        state_q       <= rd_data;
                    end
                rd_data:
                    if (m_axi_rvalid && m_axi_rlast) begin
                        m_axi_rready <= 1'b0;
                        state_q      <= rd_done;
                    end
                default:
                    state_q <= rd_idle;  // rd_done lasts one cycle
            endcase
        end
    end

    // address and data registers
    always_ff @(posedge clk) begin
        if (state_q == rd_idle && rd.req) m_axi_araddr <= rd.addr;
        if (state_q == rd_data && m_axi_rvalid && m_axi_rlast) data_q <= m_axi_rdata;
    end

    always_comb begin
        rd.done = (state_q == rd_done);
        rd.data = data_q;
    end

    // fixed single-beat 64-bit reads
    always_comb begin
        m_axi_arlen   = `AXI_LEN_SINGLE;
        m_axi_arsize  = `AXI_SIZE_8B;
        m_axi_arburst = `AXI_BURST_INCR;
        m_axi_arid    = `AXI_ID_ZERO;
    end

endmodule

`default_nettype wire

/* design/page_walker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ptw_consts.svh"

module page_walker
    import ptw_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    walk_if.walker    walk,
    pte_rd_if.walker  rd
);

    walk_state_t                            state_q;
    logic [2:0]                             level_q;  // 4 .. 0
    logic [`PTW_PPN_W-1:0]                  ppn_q;    // current table, then result page
    logic [7:0]                             perm_q;
    pte_t                                   pte_q;
    pte_t                                   leaf_pte; // pte with superpage fields filled
    logic                                   misaligned;
    logic                                   is_leaf;
    logic [`PTW_LEVELS-1:0][`PTW_VPN_W-1:0] vpn;

    // vpn fields straight from the held request
    always_comb vpn = walk.vadd[`PTW_PGOFF_W +: `PTW_LEVELS*`PTW_VPN_W];

    always_comb is_leaf = pte_q.flat.flags[`PTE_R] | pte_q.flat.flags[`PTE_X];

    // fields below the leaf level must be zero and take the vpn instead
    always_comb begin
        leaf_pte   = pte_q;
        misaligned = 1'b0;
        for (int i = 0; i < `PTW_LEVELS-1; i++) begin
            if (i < int'(level_q)) begin
                if (|pte_q.lvl.ppn_lvl[i]) misaligned = 1'b1;
                leaf_pte.lvl.ppn_lvl[i] = vpn[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle:
                    if (|walk.id) begin
                        ppn_q <= walk.satp[`PTW_PPN_W-1:0];  // root table
                        case (walk.satp[`PTW_XLEN-1 -: `PTW_MODE_W])
                            `PTW_MODE_SV39: begin
                                level_q <= 3'd2;
                                state_q <= st_addr;
                            end
                            `PTW_MODE_SV48: begin
                                level_q <= 3'd3;
                                state_q <= st_addr;
                            end
                            `PTW_MODE_SV57: begin
                                level_q <= 3'd4;
                                state_q <= st_addr;
                            end
                            default: begin  // bare or unknown mode faults
                                perm_q  <= '0;
                                state_q <= st_done;
                            end
                        endcase
                    end
                st_addr:
                    state_q <= st_wait_pte;  // req goes out this cycle
                st_wait_pte:
                    if (rd.done) begin
                        pte_q   <= rd.data;
                        state_q <= st_decode;
                    end
                st_decode:
                    if (!pte_q.flat.flags[`PTE_V]) begin
                        perm_q  <= '0;
                        state_q <= st_done;
                    end else if (is_leaf) begin
                        perm_q  <= misaligned ? 8'd0 : pte_q.flat.flags;
                        ppn_q   <= leaf_pte.flat.ppn;
                        state_q <= st_done;
                    end else if (level_q == 3'd0) begin  // pointer at the last level
                        perm_q  <= '0;
                        state_q <= st_done;
                    end else begin
                        ppn_q   <= pte_q.flat.ppn;
                        level_q <= level_q - 3'd1;
                        state_q <= st_addr;
                    end
                st_done:
                    state_q <= st_idle;
                default:
                    state_q <= st_idle;
            endcase
        end
    end

    // pte address: table base plus 8 * vpn of this level
    always_comb begin
        rd.req  = (state_q == st_addr);
        rd.addr = {{(`PTW_XLEN-`PTW_PPN_W-`PTW_VPN_W-3){1'b0}}, ppn_q, vpn[level_q], 3'b000};
    end

    always_comb begin
        walk.resp_id = (state_q == st_done) ? walk.id : '0;
        walk.perm    = perm_q;
        walk.padd    = {{(`PTW_XLEN-`PTW_PPN_W-`PTW_PGOFF_W){1'b0}}, ppn_q,
                        {`PTW_PGOFF_W{1'b0}}};
    end

endmodule

`default_nettype wire

/* design/pte_rd_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ptw_consts.svh"

interface pte_rd_if;

    logic                 req;   // one-cycle strobe
    logic [`PTW_XLEN-1:0] addr;  // valid with req
    logic                 done;  // one-cycle strobe
    logic [`PTW_XLEN-1:0] data;  // valid with done

    modport walker (
        output req, addr,
        input  done, data
    );

    modport reader (
        input  req, addr,
        output done, data
    );

endinterface

`default_nettype wire

/* design/ptw_pkg.sv */
`default_nettype none

`include "ptw_consts.svh"

package ptw_pkg;

    // one page table entry, decoded two ways
    typedef union packed {
        struct packed {
            logic [`PTW_XLEN-`PTW_PPN_W-`PTE_RSW_W-`PTE_FLAGS_W-1:0] rsvd;
            logic [`PTW_PPN_W-1:0]                                  ppn;  // next table or page
            logic [`PTE_RSW_W-1:0]                                  rsw;
            logic [`PTE_FLAGS_W-1:0]                                flags;
        } flat;
        struct packed {
            logic [`PTW_XLEN-`PTW_PPN_W-`PTE_RSW_W-`PTE_FLAGS_W-1:0] rsvd;
            logic [`PTW_PPN_W-(`PTW_LEVELS-1)*`PTW_VPN_W-1:0]       ppn_top; // ppn[4], 8 bits
            logic [`PTW_LEVELS-2:0][`PTW_VPN_W-1:0]                 ppn_lvl; // ppn[3] .. ppn[0]
            logic [`PTE_RSW_W-1:0]                                  rsw;
            logic [`PTE_FLAGS_W-1:0]                                flags;
        } lvl;
    } pte_t;

    typedef enum logic [2:0] {
        st_idle,      // waiting for a held request
        st_addr,      // pte address out to the reader
        st_wait_pte,  // read in flight
        st_decode,    // look at the returned entry
        st_done       // result valid, resp_id driven
    } walk_state_t;

endpackage

`default_nettype wire

/* design/ptw_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ptw_consts.svh"

module ptw_top (
    input  logic                 clk,
    input  logic                 rst,
    // requester side
    input  logic [`PTW_ID_W-1:0] rqst,
    input  logic [`PTW_XLEN-1:0] vadd,
    input  logic [`PTW_XLEN-1:0] satp,
    output logic [`PTW_ID_W-1:0] resp,
    output logic [7:0]           perm,
    output logic [`PTW_XLEN-1:0] padd,
    // axi read address channel
    output logic [`PTW_ID_W-1:0] m_axi_arid,
    output logic [`PTW_XLEN-1:0] m_axi_araddr,
    output logic [7:0]           m_axi_arlen,
    output logic [2:0]           m_axi_arsize,
    output logic [1:0]           m_axi_arburst,
    output logic                 m_axi_arvalid,
    input  logic                 m_axi_arready,
    // axi read data channel
    input  logic [`PTW_XLEN-1:0] m_axi_rdata,
    input  logic                 m_axi_rlast,
    input  logic                 m_axi_rvalid,
    output logic                 m_axi_rready
);

    walk_if   walk_bus ();
    pte_rd_if rd_bus ();

    walk_req_buffer walk_req_buffer_i (
        .clk  (clk),
        .rst  (rst),
        .rqst (rqst),
        .vadd (vadd),
        .satp (satp),
        .resp (resp),
        .perm (perm),
        .padd (padd),
        .walk (walk_bus.buffer)
    );

    page_walker page_walker_i (
        .clk  (clk),
        .rst  (rst),
        .walk (walk_bus.walker),
        .rd   (rd_bus.walker)
    );

    axi_pte_reader axi_pte_reader_i (
        .clk           (clk),
        .rst           (rst),
        .rd            (rd_bus.reader),
        .m_axi_araddr  (m_axi_araddr),
        .m_axi_arvalid (m_axi_arvalid),
        .m_axi_arready (m_axi_arready),
        .m_axi_arlen   (m_axi_arlen),
        .m_axi_arsize  (m_axi_arsize),
        .m_axi_arburst (m_axi_arburst),
        .m_axi_arid    (m_axi_arid),
        .m_axi_rdata   (m_axi_rdata),
        .m_axi_rlast   (m_axi_rlast),
        .m_axi_rvalid  (m_axi_rvalid),
        .m_axi_rready  (m_axi_rready)
    );

endmodule

`default_nettype wire

/* design/walk_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ptw_consts.svh"

interface walk_if;

    logic [`PTW_ID_W-1:0] id;       // held request, 0 when none
    logic [`PTW_XLEN-1:0] vadd;
    logic [`PTW_XLEN-1:0] satp;
    logic [`PTW_ID_W-1:0] resp_id;  // equals id for one cycle at the end
    logic [7:0]           perm;
    logic [`PTW_XLEN-1:0] padd;

    modport buffer (
        output id, vadd, satp,
        input  resp_id, perm, padd
    );

    modport walker (
        input  id, vadd, satp,
        output resp_id, perm, padd
    );

endinterface

`default_nettype wire

/* design/walk_req_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ptw_consts.svh"

module walk_req_buffer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`PTW_ID_W-1:0] rqst,
    input  logic [`PTW_XLEN-1:0] vadd,
    input  logic [`PTW_XLEN-1:0] satp,
    output logic [`PTW_ID_W-1:0] resp,
    output logic [7:0]           perm,
    output logic [`PTW_XLEN-1:0] padd,
    walk_if.buffer               walk
);

    logic                 ready;
    logic [`PTW_ID_W-1:0] id_q;
    logic [`PTW_XLEN-1:0] vadd_q;
    logic [`PTW_XLEN-1:0] satp_q;

    // free, or the walker is answering the held id right now
    always_comb ready = ~|id_q | (id_q == walk.resp_id);

    always_ff @(posedge clk) begin
        if (rst) begin
            id_q <= '0;
        end else if (ready) begin
            id_q <= rqst;  // 0 here just means nothing pending
        end
    end

    always_ff @(posedge clk) begin
        if (ready) begin
            vadd_q <= vadd;
            satp_q <= satp;
        end
    end

    always_comb begin
        walk.id   = id_q;
        walk.vadd = vadd_q;
        walk.satp = satp_q;
    end

    // result goes back to the requester in the same cycle
    always_comb begin
        resp = walk.resp_id;
        perm = walk.perm;
        padd = walk.padd;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+include
design/ptw_pkg.sv
design/walk_if.sv
design/pte_rd_if.sv
design/walk_req_buffer.sv
design/page_walker.sv
design/axi_pte_reader.sv
design/ptw_top.sv
verif/ptw_chk.sv
verif/ptw_tb.sv

/* include/ptw_consts.svh */
`ifndef PTW_CONSTS_SVH
`define PTW_CONSTS_SVH

`define PTW_ID_W     8    // request id width
`define PTW_XLEN     64   // address, satp and pte width
`define PTW_PPN_W    44   // physical page number
`define PTW_VPN_W    9    // one vpn field
`define PTW_PGOFF_W  12   // 4 KiB page offset
`define PTW_LEVELS   5    // deepest walk is sv57
`define PTW_MODE_W   4    // satp mode field at the top of satp

`define PTW_MODE_SV39 4'd8
`define PTW_MODE_SV48 4'd9
`define PTW_MODE_SV57 4'd10

`define PTE_FLAGS_W  8
`define PTE_RSW_W    2
`define PTE_V        0    // valid
`define PTE_R        1    // readable, marks a leaf
`define PTE_X        3    // executable, marks a leaf

`define AXI_LEN_SINGLE 8'd0      // one beat per read
`define AXI_SIZE_8B    3'b011
`define AXI_BURST_INCR 2'b01
`define AXI_ID_ZERO    `PTW_ID_W'(0)

`endif

/* verif/ptw_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ptw_consts.svh"

module ptw_chk
    import ptw_pkg::*;
(
    input logic                 clk,
    input logic                 rst,
    input logic [`PTW_ID_W-1:0] resp,
    input logic [`PTW_ID_W-1:0] m_axi_arid,
    input logic [`PTW_XLEN-1:0] m_axi_araddr,
    input logic                 m_axi_arvalid,
    input logic                 m_axi_arready,
    input logic [7:0]           m_axi_arlen,
    input logic [2:0]           m_axi_arsize,
    input logic [1:0]           m_axi_arburst,
    input logic                 m_axi_rready,
    input walk_state_t          walk_state
);

    int fail_cnt = 0;  // assertion failures so far

    ar_stable: assert property (@(posedge clk) disable iff (rst)
        (m_axi_arvalid && !m_axi_arready) |=> (m_axi_arvalid && $stable(m_axi_araddr)))
        else begin
            $error("arvalid or araddr changed before arready");
            fail_cnt++;
        end

    resp_one_cycle: assert property (@(posedge clk) disable iff (rst)
        (|resp) |=> !(|resp))
        else begin
            $error("resp non-zero for two cycles in a row");
            fail_cnt++;
        end

    reader_in_wait: assert property (@(posedge clk) disable iff (rst)
        (m_axi_arvalid || m_axi_rready) |-> (walk_state == st_wait_pte))  // one read per step
        else begin
            $error("axi read active while the walker is not waiting for a pte");
            fail_cnt++;
        end

    reset_values: assert property (@(posedge clk)
        rst |=> (resp == '0 && !m_axi_arvalid && !m_axi_rready))
        else begin
            $error("resp, arvalid or rready not low after reset");
            fail_cnt++;
        end

    single_beat: assert property (@(posedge clk) m_axi_arlen == 8'd0)
        else begin
            $error("arlen is not zero");
            fail_cnt++;
        end

    ar_fields: assert property (@(posedge clk) disable iff (rst)
        m_axi_arvalid |-> (m_axi_arid == '0 && m_axi_arsize == 3'b011
                           && m_axi_arburst == 2'b01))  // id 0, 8 bytes, incr
        else begin
            $error("arid, arsize or arburst wrong during a read");
            fail_cnt++;
        end

endmodule

bind ptw_top ptw_chk ptw_chk_i (
    .clk           (clk),
    .rst           (rst),
    .resp          (resp),
    .m_axi_arid    (m_axi_arid),
    .m_axi_araddr  (m_axi_araddr),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_arready (m_axi_arready),
    .m_axi_arlen   (m_axi_arlen),
    .m_axi_arsize  (m_axi_arsize),
    .m_axi_arburst (m_axi_arburst),
    .m_axi_rready  (m_axi_rready),
    .walk_state    (page_walker_i.state_q)
);

`default_nettype wire

/* verif/ptw_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ptw_consts.svh"

module ptw_tb;

    logic                 clk;
    logic                 rst;
    logic [`PTW_ID_W-1:0] rqst;
    logic [`PTW_XLEN-1:0] vadd;
    logic [`PTW_XLEN-1:0] satp;
    logic [`PTW_ID_W-1:0] resp;
    logic [7:0]           perm;
    logic [`PTW_XLEN-1:0] padd;
    logic [`PTW_ID_W-1:0] m_axi_arid;
    logic [`PTW_XLEN-1:0] m_axi_araddr;
    logic [7:0]           m_axi_arlen;
    logic [2:0]           m_axi_arsize;
    logic [1:0]           m_axi_arburst;
    logic                 m_axi_arvalid;
    logic                 m_axi_arready;
    logic [`PTW_XLEN-1:0] m_axi_rdata;
    logic                 m_axi_rlast;
    logic                 m_axi_rvalid;
    logic                 m_axi_rready;

    logic [63:0] pte_mem [logic [63:0]];  // sparse page tables, byte address
    integer      seed;
    int          ar_seen = 0;             // cycles with arvalid high
    int          errors = 0;
    int          passed = 0;
    int          failed = 0;
    logic [63:0] va_sv39;
    logic [63:0] va_sv48;
    logic [63:0] va_bad;
    logic [63:0] va_mis;
    logic [63:0] va_hole;

    ptw_top ptw_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (m_axi_arvalid) ar_seen <= ar_seen + 1;
    end

    function automatic logic [63:0] vpn_of(input logic [63:0] va, input int lvl);
        return (va >> (`PTW_PGOFF_W + `PTW_VPN_W * lvl)) & 64'h1ff;
    endfunction

    function automatic logic [63:0] pte_addr(input logic [43:0] ppn, input logic [63:0] va,
                                             input int lvl);
        return ({20'd0, ppn} << `PTW_PGOFF_W) | (vpn_of(va, lvl) << 3);
    endfunction

    function automatic logic [63:0] make_pte(input logic [43:0] ppn, input logic [7:0] flags);
        return {10'd0, ppn, 2'b00, flags};
    endfunction

    function automatic logic [63:0] make_satp(input logic [3:0] mode, input logic [43:0] ppn);
        return {mode, 16'd0, ppn};
    endfunction

    // slave side, random ready and data delays
    initial begin
        logic [63:0] addr;
        int          delay;
        m_axi_arready = 1'b0;
        m_axi_rvalid  = 1'b0;
        m_axi_rlast   = 1'b0;
        m_axi_rdata   = '0;
        forever begin
            @(negedge clk);
            if (m_axi_arvalid === 1'b1) begin
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(negedge clk);
                addr          = m_axi_araddr;
                m_axi_arready = 1'b1;
                @(negedge clk);
                m_axi_arready = 1'b0;
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(negedge clk);
                m_axi_rdata  = pte_mem.exists(addr) ? pte_mem[addr] : 64'h0;  // hole reads 0
                m_axi_rvalid = 1'b1;
                m_axi_rlast  = 1'b1;
                @(negedge clk);
                m_axi_rvalid = 1'b0;
                m_axi_rlast  = 1'b0;
            end
        end
    end

    // called on a falling edge, returns on the falling edge that sees resp
    task automatic run_walk(input string name, input logic [7:0] id, input logic [63:0] va,
                            input logic [63:0] sp, input logic [7:0] exp_perm,
                            input logic [63:0] exp_padd, input bit chk_padd,
                            input bit no_axi, input bit drop);
        int cycles;
        int errs_before;
        int ar_before;
        errs_before = errors;
        ar_before   = ar_seen;
        rqst        = id;
        vadd        = va;
        satp        = sp;
        cycles      = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (resp !== id && cycles < 200);
        if (resp !== id) begin
            $display("%s: no response for id %02h within 200 cycles", name, id);
            errors++;
        end else begin
            assert (perm === exp_perm) else begin
                $display("mismatch %s perm expected %02h actual %02h", name, exp_perm, perm);
                errors++;
            end
            if (chk_padd) begin
                assert (padd === exp_padd) else begin
                    $display("mismatch %s padd expected %016h actual %016h",
                             name, exp_padd, padd);
                    errors++;
                end
            end
            if (no_axi) begin
                assert (ar_seen == ar_before) else begin
                    $display("mismatch %s arvalid cycles expected 0 actual %0d",
                             name, ar_seen - ar_before);
                    errors++;
                end
            end
        end
        if (drop) rqst = '0;
        if (errors == errs_before) begin
            passed++;
            $display("%s: ok", name);
        end else begin
            failed++;
            $display("%s: failed", name);
        end
    endtask

    initial begin
        seed    = 24;
        rst     = 1'b1;
        rqst    = '0;
        vadd    = '0;
        satp    = '0;
        va_sv39 = (64'd1 << 30) | (64'd2 << 21) | (64'd3 << 12) | 64'habc;
        va_sv48 = (64'd4 << 39) | (64'd5 << 30) | (64'd6 << 21) | (64'h1a7 << 12) | 64'h123;
        va_bad  = (64'd8 << 30) | (64'd9 << 21) | (64'd10 << 12);
        va_mis  = (64'd7 << 30) | (64'h15 << 21) | (64'h2b << 12);
        va_hole = (64'd9 << 30) | (64'd2 << 21);  // no root entry for vpn2 9

        // sv39, three levels to a 4 KiB page
        pte_mem[pte_addr(44'h100, va_sv39, 2)] = make_pte(44'h101, 8'h01);
        pte_mem[pte_addr(44'h101, va_sv39, 1)] = make_pte(44'h102, 8'h01);
        pte_mem[pte_addr(44'h102, va_sv39, 0)] = make_pte(44'h12345, 8'hcf);
        // sv48, 2 MiB superpage at level 1
        pte_mem[pte_addr(44'h200, va_sv48, 3)] = make_pte(44'h201, 8'h01);
        pte_mem[pte_addr(44'h201, va_sv48, 2)] = make_pte(44'h202, 8'h01);
        pte_mem[pte_addr(44'h202, va_sv48, 1)] = make_pte(44'habc00, 8'h0b);
        // sv39, level 1 entry without V
        pte_mem[pte_addr(44'h300, va_bad, 2)] = make_pte(44'h301, 8'h01);
        pte_mem[pte_addr(44'h301, va_bad, 1)] = make_pte(44'h777, 8'h0e);
        // sv39, 1 GiB leaf with a non-zero ppn[0]
        pte_mem[pte_addr(44'h400, va_mis, 2)] = make_pte(44'h40005, 8'h07);

        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        run_walk("sv39_leaf", 8'h11, va_sv39, make_satp(4'd8, 44'h100), 8'hcf,
                 64'h12345 << 12, 1'b1, 1'b0, 1'b1);
        repeat (2) @(negedge clk);
        run_walk("sv48_superpage", 8'h12, va_sv48, make_satp(4'd9, 44'h200), 8'h0b,
                 (64'habc00 | vpn_of(va_sv48, 0)) << 12, 1'b1, 1'b0, 1'b1);
        repeat (2) @(negedge clk);
        run_walk("bare_mode", 8'h13, va_sv39, make_satp(4'd0, 44'h100), 8'h00,
                 64'h0, 1'b0, 1'b1, 1'b1);
        repeat (2) @(negedge clk);
        run_walk("invalid_pte", 8'h14, va_bad, make_satp(4'd8, 44'h300), 8'h00,
                 64'h0, 1'b0, 1'b0, 1'b1);
        repeat (2) @(negedge clk);
        run_walk("misaligned", 8'h15, va_mis, make_satp(4'd8, 44'h400), 8'h00,
                 64'h0, 1'b0, 1'b0, 1'b1);
        repeat (2) @(negedge clk);

        // next request goes out on the edge that sees the previous resp
        run_walk("b2b_a", 8'h21, va_sv39, make_satp(4'd8, 44'h100), 8'hcf,
                 64'h12345 << 12, 1'b1, 1'b0, 1'b0);
        run_walk("b2b_b", 8'h22, va_sv48, make_satp(4'd9, 44'h200), 8'h0b,
                 (64'habc00 | vpn_of(va_sv48, 0)) << 12, 1'b1, 1'b0, 1'b0);
        run_walk("b2b_c", 8'h23, va_hole, make_satp(4'd8, 44'h100), 8'h00,
                 64'h0, 1'b0, 1'b0, 1'b1);
        repeat (4) @(negedge clk);

        $display("tests passed %0d failed %0d assertion failures %0d", passed, failed,
                 ptw_top_i.ptw_chk_i.fail_cnt);
        if (failed == 0 && ptw_top_i.ptw_chk_i.fail_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
